/* all.f */
+incdir+logic
logic/tsp_pkg.sv
logic/table_ram.sv
logic/move_issue.sv
logic/edge_distance.sv
logic/delta_combine.sv
logic/tsp_delta_top.sv
testbench/tb_tsp_delta.sv

/* testbench/tb_tsp_delta.sv */
`timescale 1ns/1ns
`include "tsp_cfg.svh"

module tb_tsp_delta;
    import tsp_pkg::*;

    localparam int EXP_SLOTS = 128;

    logic       clk = 1'b0;
    logic       reset;
    logic       move_valid;
    city_t      move_k;
    city_t      move_l;
    logic       credit_return;
    logic       tour_we;
    city_t      tour_addr;
    city_t      tour_data;
    logic       dist_we;
    dist_addr_t dist_addr;
    distance_t  dist_data;
    logic       result_valid;
    delta_t     result_delta;
    logic       result_accept;
    city_t      result_k;
    city_t      result_l;

    city_t       tour_model [`CITY_NUM];
    int          dist_model [`CITY_NUM][`CITY_NUM];
    delta_t      exp_delta [EXP_SLOTS];
    city_t       exp_k [EXP_SLOTS];
    city_t       exp_l [EXP_SLOTS];
    delta_t      head_delta;
    city_t       head_k;
    city_t       head_l;
    int unsigned requested = 0;
    int unsigned sent = 0;
    int unsigned received = 0;
    int unsigned outstanding;
    int          credits = `MOVE_DEPTH;
    logic        checks_on = 1'b0;
    logic        timed_out = 1'b0;
    string       test_name;
    int          err_reset = 0;
    int          err_delta = 0;
    int          err_order = 0;
    int          err_accept = 0;
    int          err_credit = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    tsp_delta_top UUT (
        .clk(clk), .reset(reset), .move_valid(move_valid), .move_k(move_k), .move_l(move_l),
        .credit_return(credit_return), .tour_we(tour_we), .tour_addr(tour_addr),
        .tour_data(tour_data), .dist_we(dist_we), .dist_addr(dist_addr), .dist_data(dist_data),
        .result_valid(result_valid), .result_delta(result_delta),
        .result_accept(result_accept), .result_k(result_k), .result_l(result_l)
    );

    always #10 clk = ~clk;

    assign head_delta  = exp_delta[received % EXP_SLOTS];  // oldest outstanding move
    assign head_k      = exp_k[received % EXP_SLOTS];
    assign head_l      = exp_l[received % EXP_SLOTS];
    assign outstanding = sent - received;

    // delta of reversing positions k..l from the added and removed edges
    function automatic delta_t model_delta(input int k, input int l);
        int a;
        int b;
        int c;
        int e;
        int added;
        int removed;
        a = tour_model[k-1];
        b = tour_model[k];
        c = tour_model[l];
        e = tour_model[l+1];
        added   = dist_model[a][c] + dist_model[b][e];
        removed = dist_model[a][b] + dist_model[c][e];
        return delta_t'(added - removed);
    endfunction

    // the move source sends whenever it holds a credit and moves are still requested
    always @(posedge clk) begin
        city_t k;
        city_t l;
        logic  send;
        send = (sent < requested) && (credits > 0);
        if (send) begin
            k = city_t'(1 + $urandom % (`CITY_NUM - 3));
            l = city_t'(k + 1 + $urandom % (`CITY_NUM - 2 - k));
            move_valid <= 1'b1;
            move_k     <= k;
            move_l     <= l;
            exp_delta[sent % EXP_SLOTS] <= model_delta(k, l);
            exp_k[sent % EXP_SLOTS]     <= k;
            exp_l[sent % EXP_SLOTS]     <= l;
            sent <= sent + 1;
        end else begin
            move_valid <= 1'b0;
        end
        credits <= credits - (send ? 1 : 0) + ((credit_return === 1'b1) ? 1 : 0);
        if (result_valid === 1'b1) begin
            received <= received + 1;
        end
    end

    quiet_after_reset: assert property (@(posedge clk)
        (checks_on && sent == 0) |-> (!result_valid && !credit_return))
        else begin
            err_reset++;
            $display("result_valid or credit_return went high before any move was sent");
        end

    delta_matches: assert property (@(posedge clk) (checks_on && result_valid) |->
        result_delta == head_delta)
        else begin
            err_delta++;
            $display("Mismatch %s delta: expected %0d actual %0d", test_name,
                $sampled(head_delta), $sampled(result_delta));
        end

    move_matches: assert property (@(posedge clk) (checks_on && result_valid) |->
        (result_k == head_k && result_l == head_l))
        else begin
            err_order++;
            $display("Mismatch %s move: expected (%0d,%0d) actual (%0d,%0d)", test_name,
                $sampled(head_k), $sampled(head_l), $sampled(result_k), $sampled(result_l));
        end

    accept_matches: assert property (@(posedge clk) (checks_on && result_valid) |->
        result_accept == (head_delta < 0))
        else begin
            err_accept++;
            $display("Mismatch %s accept: expected %0b actual %0b", test_name,
                $sampled(head_delta < 0), $sampled(result_accept));
        end

    credit_with_result: assert property (@(posedge clk) checks_on |->
        (credit_return == result_valid && outstanding <= `MOVE_DEPTH))
        else begin
            err_credit++;
            $display("credit_return out of step with results or too many moves outstanding");
        end

    task automatic report_test(input string name, input int errors);
        if (errors == 0) begin
            tests_passed++;
            $display("test %-8s ok", name);
        end else begin
            tests_failed++;
            $display("test %-8s failed with %0d errors", name, errors);
        end
    endtask

    task automatic finish_run();
        int total;
        total = err_reset + err_delta + err_order + err_accept + err_credit;
        $display("tests passed %0d, failed %0d, check errors %0d, results %0d of %0d",
            tests_passed, tests_failed, total, received, requested);
        if (total == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic wait_results(input int unsigned limit);
        int unsigned cycles;
        cycles = 0;
        while (received != requested && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (received != requested) begin
            $display("timed out in %s waiting for results, %0d of %0d arrived", test_name,
                received, requested);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_moves(input int unsigned count);
        requested <= requested + count;
        @(posedge clk);
        wait_results(count * 8 + 200);
    endtask

    task automatic load_tour();
        int    j;
        city_t t;
        for (int i = 0; i < `CITY_NUM; i++) begin
            tour_model[i] = city_t'(i);
        end
        for (int i = `CITY_NUM - 1; i > 0; i--) begin
            j = $urandom % (i + 1);
            t = tour_model[i];
            tour_model[i] = tour_model[j];
            tour_model[j] = t;
        end
        for (int i = 0; i < `CITY_NUM; i++) begin
            @(posedge clk);
            tour_we   <= 1'b1;
            tour_addr <= city_t'(i);
            tour_data <= tour_model[i];
        end
        @(posedge clk);
        tour_we <= 1'b0;
    endtask

    task automatic load_distances();
        distance_t value;
        for (int a = 1; a < `CITY_NUM; a++) begin
            for (int b = 0; b < a; b++) begin
                value = distance_t'($urandom);
                dist_model[a][b] = value;
                dist_model[b][a] = value;
                @(posedge clk);
                dist_we   <= 1'b1;
                dist_addr <= dist_addr_t'(a * (a - 1) / 2 + b);  // lower triangle address for a > b
                dist_data <= value;
            end
        end
        @(posedge clk);
        dist_we <= 1'b0;
    endtask

    initial begin
        int reload_base;
        void'($urandom(32'h2819_d128));
        reset      = 1'b1;
        move_valid = 1'b0;
        move_k     = '0;
        move_l     = '0;
        tour_we    = 1'b0;
        tour_addr  = '0;
        tour_data  = '0;
        dist_we    = 1'b0;
        dist_addr  = '0;
        dist_data  = '0;
        test_name  = "reset";
        @(posedge clk);
        checks_on <= 1'b1;  // outputs are defined from the first reset edge on
        repeat (7) @(posedge clk);
        reset <= 1'b0;
        load_tour();
        load_distances();
        repeat (20) @(posedge clk);
        report_test("reset", err_reset);

        test_name = "delta";
        run_moves(60);
        if (!timed_out) begin
            report_test("delta", err_delta + err_order);
            report_test("accept", err_accept);
            assert (credits == `MOVE_DEPTH)
                else begin
                    err_credit++;
                    $display("source holds %0d credits after all results, not all were returned",
                        credits);
                end
            report_test("credits", err_credit);

            test_name   = "reload";
            reload_base = err_delta + err_order + err_accept;
            load_distances();
            run_moves(40);
            if (!timed_out) begin
                report_test("reload", err_delta + err_order + err_accept - reload_base);
            end
        end
        finish_run();
    end

endmodule

/* logic/tsp_delta_top.sv */
`timescale 1ns/1ns
`include "tsp_cfg.svh"

module tsp_delta_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                move_valid,
    input  tsp_pkg::city_t      move_k,
    input  tsp_pkg::city_t      move_l,
    output logic                credit_return,
    input  logic                tour_we,
    input  tsp_pkg::city_t      tour_addr,
    input  tsp_pkg::city_t      tour_data,
    input  logic                dist_we,
    input  tsp_pkg::dist_addr_t dist_addr,
    input  tsp_pkg::distance_t  dist_data,
    output logic                result_valid,
    output tsp_pkg::delta_t     result_delta,
    output logic                result_accept,
    output tsp_pkg::city_t      result_k,
    output tsp_pkg::city_t      result_l
);
    import tsp_pkg::*;

    edge_select_t rem_select;
    edge_select_t add_select;
    edge_op_t     rem_op;
    edge_op_t     add_op;
    logic         cmd_last;
    move_t        cmd_move;
    city_t        rem_ord_addr;
    city_t        rem_ord_data;
    city_t        add_ord_addr;
    city_t        add_ord_data;
    dist_addr_t   rem_dist_addr;
    distance_t    rem_dist_data;
    dist_addr_t   add_dist_addr;
    distance_t    add_dist_data;
    delta_t       rem_sum;
    delta_t       add_sum;
    logic         sum_valid;
    move_t        sum_move;

    move_issue u_issue (
        .clk(clk), .reset(reset), .move_valid(move_valid), .move_k(move_k), .move_l(move_l),
        .rem_select(rem_select), .add_select(add_select), .rem_op(rem_op), .add_op(add_op),
        .cmd_last(cmd_last), .cmd_move(cmd_move)
    );

    table_ram #(.payload_t(city_t), .ADDR_BITS(`CITY_NUM_LOG)) u_rem_ordering (
        .clk(clk), .we(tour_we), .waddr(tour_addr), .raddr(rem_ord_addr),
        .wdata(tour_data), .rdata(rem_ord_data)
    );

    table_ram #(.payload_t(city_t), .ADDR_BITS(`CITY_NUM_LOG)) u_add_ordering (
        .clk(clk), .we(tour_we), .waddr(tour_addr), .raddr(add_ord_addr),
        .wdata(tour_data), .rdata(add_ord_data)
    );

    table_ram #(.payload_t(distance_t), .ADDR_BITS(2*`CITY_NUM_LOG-1)) u_rem_distance (
        .clk(clk), .we(dist_we), .waddr(dist_addr), .raddr(rem_dist_addr),
        .wdata(dist_data), .rdata(rem_dist_data)
    );

    table_ram #(.payload_t(distance_t), .ADDR_BITS(2*`CITY_NUM_LOG-1)) u_add_distance (
        .clk(clk), .we(dist_we), .waddr(dist_addr), .raddr(add_dist_addr),
        .wdata(dist_data), .rdata(add_dist_data)
    );

    edge_distance u_rem_edge (
        .clk(clk), .reset(reset), .select(rem_select), .op(rem_op), .last(cmd_last),
        .move(cmd_move), .ordering_addr(rem_ord_addr), .ordering_data(rem_ord_data),
        .distance_addr(rem_dist_addr), .distance_data(rem_dist_data),
        .sum(rem_sum), .sum_valid(sum_valid), .sum_move(sum_move)
    );

    // same timing as the removed unit, so its valid and tag are not needed
    edge_distance u_add_edge (
        .clk(clk), .reset(reset), .select(add_select), .op(add_op), .last(cmd_last),
        .move(cmd_move), .ordering_addr(add_ord_addr), .ordering_data(add_ord_data),
        .distance_addr(add_dist_addr), .distance_data(add_dist_data),
        .sum(add_sum), .sum_valid(), .sum_move()
    );

    delta_combine u_combine (
        .clk(clk), .reset(reset), .rem_sum(rem_sum), .add_sum(add_sum),
        .sum_valid(sum_valid), .sum_move(sum_move), .result_valid(result_valid),
        .result_delta(result_delta), .result_accept(result_accept),
        .result_k(result_k), .result_l(result_l), .credit_return(credit_return)
    );

endmodule

/* logic/delta_combine.sv */
`timescale 1ns/1ns

module delta_combine (
    input  logic             clk,
    input  logic             reset,
    input  tsp_pkg::delta_t  rem_sum,
    input  tsp_pkg::delta_t  add_sum,
    input  logic             sum_valid,
    input  tsp_pkg::move_t   sum_move,
    output logic             result_valid,
    output tsp_pkg::delta_t  result_delta,
    output logic             result_accept,
    output tsp_pkg::city_t   result_k,
    output tsp_pkg::city_t   result_l,
    output logic             credit_return
);
    import tsp_pkg::*;

    delta_t diff;

    assign diff = add_sum - rem_sum;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid  <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            result_valid  <= sum_valid;
            credit_return <= sum_valid;  // each result frees one queue slot upstream
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            result_delta  <= diff;
            result_accept <= diff[$bits(delta_t)-1];  // a shorter tour has a negative delta
            result_k      <= sum_move.k;
            result_l      <= sum_move.l;
        end
    end

endmodule

/* logic/edge_distance.sv */
`timescale 1ns/1ns

module edge_distance (
    input  logic                  clk,
    input  logic                  reset,
    input  tsp_pkg::edge_select_t select,
    input  tsp_pkg::edge_op_t     op,
    input  logic                  last,
    input  tsp_pkg::move_t        move,
    output tsp_pkg::city_t        ordering_addr,
    input  tsp_pkg::city_t        ordering_data,
    output tsp_pkg::dist_addr_t   distance_addr,
    input  tsp_pkg::distance_t    distance_data,
    output tsp_pkg::delta_t       sum,
    output logic                  sum_valid,
    output tsp_pkg::move_t        sum_move
);
    import tsp_pkg::*;

    localparam int CW         = $bits(city_t);
    localparam int OP_STAGES  = 8;  // op meets the latched distance after eight edges
    localparam int TAG_STAGES = 9;  // one more edge for the accumulate

    edge_op_t        op_d   [OP_STAGES];
    logic            last_d [TAG_STAGES];
    move_t           move_d [TAG_STAGES];
    city_t           cur_city;
    city_t           prev_city;
    city_t           city_hi;
    city_t           city_lo;
    city_t           lo_d;
    logic [2*CW-1:0] hi_product;
    distance_t       dist_l;
    delta_t          acc;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < OP_STAGES; i++) begin
                op_d[i] <= DNOP;
            end
            for (int i = 0; i < TAG_STAGES; i++) begin
                last_d[i] <= 1'b0;
            end
            sum_valid <= 1'b0;
        end else begin
            op_d[0]   <= op;
            last_d[0] <= last;
            for (int i = 1; i < OP_STAGES; i++) begin
                op_d[i] <= op_d[i-1];
            end
            for (int i = 1; i < TAG_STAGES; i++) begin
                last_d[i] <= last_d[i-1];
            end
            sum_valid <= last_d[TAG_STAGES-1];
        end
    end

    always_ff @(posedge clk) begin
        move_d[0] <= move;
        for (int i = 1; i < TAG_STAGES; i++) begin
            move_d[i] <= move_d[i-1];
        end
    end

    always_ff @(posedge clk) begin
        case (select)
            KN:      ordering_addr <= move.k;
            KM:      ordering_addr <= move.k - 1'b1;
            LN:      ordering_addr <= move.l;
            LP:      ordering_addr <= move.l + 1'b1;
            default: ordering_addr <= move.k;
        endcase
    end

    // the city from the previous command is the other end of the edge
    always_ff @(posedge clk) begin
        cur_city  <= ordering_data;
        prev_city <= cur_city;
        if (cur_city > prev_city) begin
            city_hi <= cur_city;
            city_lo <= prev_city;
        end else begin
            city_hi <= prev_city;
            city_lo <= cur_city;
        end
        hi_product    <= {{CW{1'b0}}, city_hi} * ({{CW{1'b0}}, city_hi} - 1'b1);
        lo_d          <= city_lo;
        distance_addr <= dist_addr_t'(hi_product >> 1) + dist_addr_t'(lo_d);
        dist_l        <= distance_data;
    end

    always_ff @(posedge clk) begin
        case (op_d[OP_STAGES-1])
            ZERO:    acc <= '0;
            PLS:     acc <= acc + delta_t'(dist_l);
            default: acc <= acc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (last_d[TAG_STAGES-1]) begin
            sum      <= acc;  // acc already holds the last edge here
            sum_move <= move_d[TAG_STAGES-1];
        end
    end

endmodule

/* logic/move_issue.sv */
`timescale 1ns/1ns
`include "tsp_cfg.svh"

module move_issue (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  move_valid,
    input  tsp_pkg::city_t        move_k,
    input  tsp_pkg::city_t        move_l,
    output tsp_pkg::edge_select_t rem_select,
    output tsp_pkg::edge_select_t add_select,
    output tsp_pkg::edge_op_t     rem_op,
    output tsp_pkg::edge_op_t     add_op,
    output logic                  cmd_last,
    output tsp_pkg::move_t        cmd_move
);
    import tsp_pkg::*;

    localparam int PTR_BITS = $clog2(`MOVE_DEPTH);
    localparam int CNT_BITS = $clog2(`MOVE_DEPTH + 1);

    move_t               queue [`MOVE_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic [1:0]          phase;
    logic                busy;
    logic                full;
    logic                push;
    logic                pop;
    edge_select_t        rem_sel_n;
    edge_select_t        add_sel_n;
    edge_op_t            rem_op_n;
    edge_op_t            add_op_n;

    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(`MOVE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign busy = (count != '0);
    assign full = (count == CNT_BITS'(`MOVE_DEPTH));
    assign push = move_valid && !full;  // a move outside the credit window is lost
    assign pop  = busy && (phase == 2'd3);

    // removed edges (k-1,k) and (l,l+1), added edges (k-1,l) and (k,l+1)
    always_comb begin
        case (phase)
            2'd0:    {rem_sel_n, rem_op_n, add_sel_n, add_op_n} = {KM, ZERO, KM, ZERO};
            2'd1:    {rem_sel_n, rem_op_n, add_sel_n, add_op_n} = {KN, PLS, LN, PLS};
            2'd2:    {rem_sel_n, rem_op_n, add_sel_n, add_op_n} = {LN, DNOP, KN, DNOP};
            default: {rem_sel_n, rem_op_n, add_sel_n, add_op_n} = {LP, PLS, LP, PLS};
        endcase
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= '{k: move_k, l: move_l};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            phase    <= 2'd0;
            rem_op   <= DNOP;
            add_op   <= DNOP;
            cmd_last <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            if (busy) begin
                phase <= phase + 2'd1;  // wraps back to step 0 with the pop
            end
            rem_op   <= busy ? rem_op_n : DNOP;
            add_op   <= busy ? add_op_n : DNOP;
            cmd_last <= pop;
        end
    end

    always_ff @(posedge clk) begin
        rem_select <= rem_sel_n;
        add_select <= add_sel_n;
        cmd_move   <= queue[rd_ptr];  // the head move stays put for all four steps
    end

endmodule

/* logic/table_ram.sv */
`timescale 1ns/1ns

module table_ram #(
    parameter type payload_t = logic [7:0],
    parameter int  ADDR_BITS = 6
) (
    input  logic                 clk,
    input  logic                 we,
    input  logic [ADDR_BITS-1:0] waddr,
    input  logic [ADDR_BITS-1:0] raddr,
    input  payload_t             wdata,
    output payload_t             rdata
);

    localparam int WORDS = 1 << ADDR_BITS;

    payload_t mem [WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        rdata <= mem[raddr];  // read data lands one cycle after raddr
    end

endmodule

/* logic/tsp_pkg.sv */
`include "tsp_cfg.svh"

package tsp_pkg;

    // a city index or a position in the tour
    typedef logic [`CITY_NUM_LOG-1:0] city_t;

    typedef logic [2*`CITY_NUM_LOG-2:0] dist_addr_t;  // lower triangle a*(a-1)/2 + b

    typedef logic [`DIST_WIDTH-1:0] distance_t;

    // three guard bits hold a sum of two distances and the difference of two sums
    typedef logic signed [`DIST_WIDTH+2:0] delta_t;

    typedef enum logic [1:0] {
        KN,  // position k
        KM,  // position k-1
        LN,  // position l
        LP   // position l+1
    } edge_select_t;

    typedef enum logic [1:0] {
        DNOP,  // read a city but leave the sum alone
        ZERO,  // clear the sum
        PLS    // add the distance to the previous city
    } edge_op_t;

    typedef struct packed {
        city_t k;
        city_t l;
    } move_t;

endpackage

/* logic/tsp_cfg.svh */
`ifndef TSP_CFG_SVH
`define TSP_CFG_SVH

// bits in a city index, enough for up to 64 cities
`define CITY_NUM_LOG 6

// cities in the tour
`define CITY_NUM 48

// bits in one stored distance
`define DIST_WIDTH 16

// move queue depth and the credit count the source starts with
`define MOVE_DEPTH 4

`endif
